// File: bench/tb_sya.sv
`timescale 1ns/1ns
`include "sya_defines.svh"

module tb_sya import sya_cfg_pkg::*, sya_data_pkg::*; ();

    localparam int MEM_DEPTH   = 1024;
    localparam int WAIT_LIMIT  = 200;
    localparam int JOB_LIMIT   = 5000;

    // Handshake flags seen while the engine is idle
    typedef struct packed {
        logic cfg_rdy;
        logic act_addr_vld;
        logic wgt_addr_vld;
        logic ofm_wr_vld;
    } idle_t;

    logic                   clk;
    logic                   rst_n;
    sya_cfg_t               cfg_in;
    logic                   cfg_vld;
    logic                   cfg_rdy;
    logic [`SYA_ADDR_W-1:0] act_addr;
    logic                   act_addr_vld;
    logic                   act_addr_rdy;
    logic [`SYA_ADDR_W-1:0] wgt_addr;
    logic                   wgt_addr_vld;
    logic                   wgt_addr_rdy;
    act_col_t               act_dat;
    logic                   act_dat_vld;
    wgt_row_t               wgt_dat;
    logic                   wgt_dat_vld;
    logic                   dat_rdy;
    ofm_wr_t                ofm_wr;
    logic                   ofm_wr_vld;
    logic                   ofm_wr_rdy;

    act_col_t               act_mem [MEM_DEPTH];
    wgt_row_t               wgt_mem [MEM_DEPTH];
    logic [`SYA_ADDR_W-1:0] act_aq [$];
    logic [`SYA_ADDR_W-1:0] wgt_aq [$];
    ofm_wr_t                exp_q [$];
    integer                 seed;
    logic                   rand_mode;
    logic                   dat_taken;
    string                  test_name;
    int                     mismatch_cnt;
    int                     other_err_cnt;

    sya_top sya_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_in       (cfg_in),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .act_addr     (act_addr),
        .act_addr_vld (act_addr_vld),
        .act_addr_rdy (act_addr_rdy),
        .wgt_addr     (wgt_addr),
        .wgt_addr_vld (wgt_addr_vld),
        .wgt_addr_rdy (wgt_addr_rdy),
        .act_dat      (act_dat),
        .act_dat_vld  (act_dat_vld),
        .wgt_dat      (wgt_dat),
        .wgt_dat_vld  (wgt_dat_vld),
        .dat_rdy      (dat_rdy),
        .ofm_wr       (ofm_wr),
        .ofm_wr_vld   (ofm_wr_vld),
        .ofm_wr_rdy   (ofm_wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic ofm_word_t ref_tile(sya_cfg_t c, int ifm, int flt, int grp, int r);
        logic [`SYA_ADDR_W-1:0] aa;
        logic [`SYA_ADDR_W-1:0] wa;
        act_t                   a;
        wgt_t                   w;
        int                     sum;
        int                     q;
        ofm_word_t              word;
        for (int col = 0; col < `SYA_NUM_COL; col++) begin
            sum = 0;
            for (int ch = 0; ch < int'(c.chn); ch++) begin
                aa = c.act_base + c.chn * c.num_grp * ifm + c.chn * grp + ch;
                wa = c.wgt_base + c.chn * c.num_grp * flt + c.chn * grp + ch;
                a = act_mem[aa[9:0]][r];
                w = wgt_mem[wa[9:0]][col];
                sum += a * w;
            end
            // Negative sums clamp to zero before the zero point
            if (sum < 0) begin
                q = 0;
            end else begin
                q = ((sum >> c.shift) & 255) + int'(c.zp);
            end
            word[col] = q[7:0];
        end
        return word;
    endfunction

    function automatic sya_cfg_t make_cfg(int ofm_base, int act_base, int wgt_base, int grp,
                                          int ifm, int flt, int chn, int shift, int zp,
                                          loop_ord_e ord);
        sya_cfg_t c;
        c.ofm_base    = ofm_base[`SYA_ADDR_W-1:0];
        c.act_base    = act_base[`SYA_ADDR_W-1:0];
        c.wgt_base    = wgt_base[`SYA_ADDR_W-1:0];
        c.num_grp     = grp[`SYA_IDX_W-1:0];
        c.num_til_ifm = ifm[`SYA_IDX_W-1:0];
        c.num_til_flt = flt[`SYA_IDX_W-1:0];
        c.chn         = chn[`SYA_CHN_W-1:0];
        c.shift       = shift[7:0];
        c.zp          = zp[7:0];
        c.lop_ord     = ord;
        return c;
    endfunction

    function automatic idle_t read_idle();
        idle_t s;
        s.cfg_rdy      = cfg_rdy;
        s.act_addr_vld = act_addr_vld;
        s.wgt_addr_vld = wgt_addr_vld;
        s.ofm_wr_vld   = ofm_wr_vld;
        return s;
    endfunction

    task automatic check_ofm(input string name, input ofm_wr_t exp, input ofm_wr_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected addr %h data %h, actual addr %h data %h",
                     name, exp.addr, exp.data, act.addr, act.data);
        end
    endtask

    task automatic check_cfg(input string name, input idle_t exp, input idle_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected idle flags %b, actual %b", name, exp, act);
        end
    endtask

    // ==============================
    // Global buffer model
    // ==============================
    initial begin
        act_addr_rdy = 1'b0;
        wgt_addr_rdy = 1'b0;
        act_dat      = '0;
        act_dat_vld  = 1'b0;
        wgt_dat      = '0;
        wgt_dat_vld  = 1'b0;
        ofm_wr_rdy   = 1'b0;
        dat_taken    = 1'b0;
        forever begin
            @(negedge clk);
            if (dat_taken) begin
                act_dat_vld = 1'b0;
                wgt_dat_vld = 1'b0;
                dat_taken   = 1'b0;
            end
            act_addr_rdy = !rand_mode || (($random(seed) & 3) != 0);
            wgt_addr_rdy = !rand_mode || (($random(seed) & 3) != 0);
            ofm_wr_rdy   = !rand_mode || (($random(seed) & 1) != 0);
            // Return data in address order, with random gaps
            if (!act_dat_vld && act_aq.size() > 0 && (!rand_mode || ($random(seed) & 1))) begin
                act_dat     = act_mem[act_aq[0][9:0]];
                wgt_dat     = wgt_mem[wgt_aq[0][9:0]];
                act_dat_vld = 1'b1;
                wgt_dat_vld = 1'b1;
            end
            #1;
            if (act_addr_vld && act_addr_rdy && wgt_addr_vld && wgt_addr_rdy) begin
                act_aq.push_back(act_addr);
                wgt_aq.push_back(wgt_addr);
            end
            if (act_dat_vld && wgt_dat_vld && dat_rdy) begin
                void'(act_aq.pop_front());
                void'(wgt_aq.pop_front());
                dat_taken = 1'b1;
            end
        end
    end

    // Output write monitor
    initial begin
        ofm_wr_t exp;
        forever begin
            @(negedge clk);
            #2;
            if (ofm_wr_vld && ofm_wr_rdy) begin
                if (exp_q.size() == 0) begin
                    other_err_cnt++;
                    $display("%s: output write to %h arrived with none expected",
                             test_name, ofm_wr.addr);
                end else begin
                    exp = exp_q.pop_front();
                    check_ofm(test_name, exp, ofm_wr);
                end
            end
        end
    end

    // ==============================
    // Job sequencing
    // ==============================
    task automatic wait_idle(input string name);
        int cnt;
        cnt = 0;
        while (!cfg_rdy && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!cfg_rdy) begin
            other_err_cnt++;
            $display("%s: timed out waiting for cfg_rdy", name);
        end
    endtask

    task automatic run_job(input string name, input sya_cfg_t c);
        int      n_tile;
        int      outer_n;
        int      inner_n;
        int      ifm;
        int      flt;
        int      cnt;
        ofm_wr_t w;
        test_name = name;
        wait_idle(name);
        n_tile  = 0;
        outer_n = (c.lop_ord == FLT_INNER) ? int'(c.num_til_ifm) : int'(c.num_til_flt);
        inner_n = (c.lop_ord == FLT_INNER) ? int'(c.num_til_flt) : int'(c.num_til_ifm);
        for (int o = 0; o < outer_n; o++) begin
            for (int i = 0; i < inner_n; i++) begin
                for (int g = 0; g < int'(c.num_grp); g++) begin
                    ifm = (c.lop_ord == FLT_INNER) ? o : i;
                    flt = (c.lop_ord == FLT_INNER) ? i : o;
                    for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                        w.addr = c.ofm_base + 16'(n_tile * `SYA_NUM_ROW + r);
                        w.data = ref_tile(c, ifm, flt, g, r);
                        exp_q.push_back(w);
                    end
                    n_tile++;
                end
            end
        end
        @(negedge clk);
        cfg_in  = c;
        cfg_vld = 1'b1;
        @(negedge clk);
        cfg_vld = 1'b0;
        cnt = 0;
        while ((exp_q.size() != 0 || !cfg_rdy) && cnt < JOB_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_q.size() != 0 || !cfg_rdy) begin
            other_err_cnt++;
            $display("%s: job did not finish, %0d writes still missing", name, exp_q.size());
            exp_q.delete();
        end
        check_cfg(name, 4'b1000, read_idle());
    endtask

    initial begin
        seed          = 77;
        rand_mode     = 1'b0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        test_name     = "reset";
        rst_n         = 1'b0;
        cfg_in        = '0;
        cfg_vld       = 1'b0;
        // Upper half holds positive activations and weights negative in columns 0 and 2
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                act_mem[a][r] = 8'($random(seed));
                wgt_mem[a][r] = 8'($random(seed));
            end
            if (a >= MEM_DEPTH / 2) begin
                for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                    act_mem[a][r][7] = 1'b0;
                end
                wgt_mem[a][0][7] = 1'b1;
                wgt_mem[a][2][7] = 1'b1;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_cfg("reset", 4'b1000, read_idle());

        run_job("single_tile", make_cfg(100, 0, 40, 1, 1, 1, 5, 0, 0, FLT_INNER));
        run_job("flt_inner", make_cfg(1000, 64, 200, 2, 2, 3, 3, 4, 3, FLT_INNER));
        run_job("ifm_inner", make_cfg(1000, 64, 200, 2, 2, 3, 3, 4, 3, IFM_INNER));
        rand_mode = 1'b1;
        run_job("backpressure", make_cfg(2000, 300, 400, 2, 2, 2, 7, 5, 9, FLT_INNER));
        rand_mode = 1'b0;
        run_job("neg_quant", make_cfg(3000, 600, 700, 1, 2, 2, 4, 2, 17, IFM_INNER));

        // Idle window to catch stray writes
        repeat (10) @(negedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the systolic engine testbench with Verilator
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing -Wno-fatal --top-module tb_sya \
        -f verilog.f -Mdir obj_dir -o tb_sya; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sya > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: source/sya_cfg_pkg.sv
`include "sya_defines.svh"

package sya_cfg_pkg;

    // Which tile counter moves first after the group counter wraps
    typedef enum logic {
        FLT_INNER = 1'b0,
        IFM_INNER = 1'b1
    } loop_ord_e;

    // Job configuration, 123 bits
    typedef struct packed {
        logic [`SYA_ADDR_W-1:0] ofm_base;
        logic [`SYA_ADDR_W-1:0] act_base;
        logic [`SYA_ADDR_W-1:0] wgt_base;
        logic [`SYA_IDX_W-1:0]  num_grp;
        logic [`SYA_IDX_W-1:0]  num_til_ifm;
        logic [`SYA_IDX_W-1:0]  num_til_flt;
        logic [`SYA_CHN_W-1:0]  chn;
        logic [`SYA_QNT_W-1:0]  shift;
        logic [`SYA_QNT_W-1:0]  zp;
        loop_ord_e              lop_ord;
    } sya_cfg_t;

endpackage

// File: source/sya_data_pkg.sv
`include "sya_defines.svh"

package sya_data_pkg;

    typedef logic signed [`SYA_ACT_W-1:0] act_t;
    typedef logic signed [`SYA_WGT_W-1:0] wgt_t;

    // One activation read word, element r feeds row r
    typedef act_t [`SYA_NUM_ROW-1:0] act_col_t;

    // One weight read word, element c feeds column c
    typedef wgt_t [`SYA_NUM_COL-1:0] wgt_row_t;

    typedef logic signed [`SYA_PSUM_W-1:0] psum_t;
    typedef psum_t [`SYA_NUM_COL-1:0] psum_row_t;

    // Quantized output row, column 0 in the low byte
    typedef logic [`SYA_NUM_COL-1:0][`SYA_QNT_W-1:0] ofm_word_t;

    typedef struct packed {
        logic [`SYA_ADDR_W-1:0] addr;
        ofm_word_t              data;
    } ofm_wr_t;

endpackage

// File: source/sya_defines.svh
`ifndef SYA_DEFINES_SVH
`define SYA_DEFINES_SVH

// ==============================
// Array geometry
// ==============================
`define SYA_NUM_ROW 4
`define SYA_NUM_COL 4

// ==============================
// Data and index widths
// ==============================
`define SYA_ACT_W   8
`define SYA_WGT_W   8
`define SYA_CHN_W   10
`define SYA_IDX_W   16
`define SYA_ADDR_W  16

// Shift amount, zero point and output byte
`define SYA_QNT_W   8

// Enough headroom for 2**CHN_W full-scale products
`define SYA_PSUM_W  (`SYA_ACT_W + `SYA_WGT_W + `SYA_CHN_W)

// Empty steps that push the last channel through to the far corner PE
`define SYA_FLUSH_STEPS (`SYA_NUM_ROW + `SYA_NUM_COL - 2)

`endif

// File: source/sya_loop_seq.sv
`timescale 1ns/1ns
`include "sya_defines.svh"

module sya_loop_seq import sya_cfg_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sya_cfg_t               cfg_in,
    input  logic                   cfg_vld,
    output logic                   cfg_rdy,
    output sya_cfg_t               cfg,
    output logic                   cfg_load,
    output logic [`SYA_ADDR_W-1:0] act_addr,
    output logic                   act_addr_vld,
    input  logic                   act_addr_rdy,
    output logic [`SYA_ADDR_W-1:0] wgt_addr,
    output logic                   wgt_addr_vld,
    input  logic                   wgt_addr_rdy,
    input  logic                   tile_done
);

    localparam int ADDR_W = `SYA_ADDR_W;
    localparam int IDX_W  = `SYA_IDX_W;
    localparam int CHN_W  = `SYA_CHN_W;

    typedef enum logic [1:0] {IDLE, ISSUE, FINISH} seq_st_e;

    seq_st_e           state;
    logic [CHN_W-1:0]  cnt_chn;
    logic [IDX_W-1:0]  cnt_grp;
    logic [IDX_W-1:0]  cnt_flt;
    logic [IDX_W-1:0]  cnt_ifm;
    logic [IDX_W-1:0]  cnt_out;
    logic [IDX_W-1:0]  cnt_out_nxt;
    logic [ADDR_W-1:0] chn_a;
    logic [ADDR_W-1:0] stride;
    logic              beat;
    logic              last_chn;
    logic              last_grp;
    logic              last_flt;
    logic              last_ifm;
    logic              inc_grp;
    logic              inc_flt;
    logic              inc_ifm;
    logic              tile_up;

    // ==============================
    // Issue handshake
    // ==============================
    assign cfg_rdy      = state == IDLE;
    assign act_addr_vld = (state == ISSUE) & wgt_addr_rdy;
    assign wgt_addr_vld = (state == ISSUE) & act_addr_rdy;
    assign beat         = (state == ISSUE) & act_addr_rdy & wgt_addr_rdy;

    // ==============================
    // Loop counter chain
    // ==============================
    assign last_chn = cnt_chn == cfg.chn - 1'b1;
    assign last_grp = cnt_grp == cfg.num_grp - 1'b1;
    assign last_flt = cnt_flt == cfg.num_til_flt - 1'b1;
    assign last_ifm = cnt_ifm == cfg.num_til_ifm - 1'b1;

    assign tile_up = beat & last_chn;
    assign inc_grp = tile_up;
    assign inc_flt = (cfg.lop_ord == FLT_INNER) ? inc_grp & last_grp
                                                : inc_grp & last_grp & last_ifm;
    assign inc_ifm = (cfg.lop_ord == FLT_INNER) ? inc_grp & last_grp & last_flt
                                                : inc_grp & last_grp;

    // Address = base + chn*num_grp*tile + chn*grp + ch
    assign chn_a    = {{(ADDR_W-CHN_W){1'b0}}, cfg.chn};
    assign stride   = chn_a * cfg.num_grp;
    assign act_addr = cfg.act_base + stride * cnt_ifm + chn_a * cnt_grp
                    + {{(ADDR_W-CHN_W){1'b0}}, cnt_chn};
    assign wgt_addr = cfg.wgt_base + stride * cnt_flt + chn_a * cnt_grp
                    + {{(ADDR_W-CHN_W){1'b0}}, cnt_chn};

    // Tiles issued but not yet written out
    assign cnt_out_nxt = cnt_out + IDX_W'(tile_up) - IDX_W'(tile_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            cfg      <= '0;
            cfg_load <= 1'b0;
            cnt_chn  <= '0;
            cnt_grp  <= '0;
            cnt_flt  <= '0;
            cnt_ifm  <= '0;
            cnt_out  <= '0;
        end else begin
            cfg_load <= cfg_vld & cfg_rdy;
            cnt_out  <= cnt_out_nxt;
            if (cfg_vld & cfg_rdy) begin
                cfg <= cfg_in;
            end
            if (beat) begin
                cnt_chn <= last_chn ? '0 : cnt_chn + 1'b1;
            end
            if (inc_grp) begin
                cnt_grp <= last_grp ? '0 : cnt_grp + 1'b1;
            end
            if (inc_flt) begin
                cnt_flt <= last_flt ? '0 : cnt_flt + 1'b1;
            end
            if (inc_ifm) begin
                cnt_ifm <= last_ifm ? '0 : cnt_ifm + 1'b1;
            end
            case (state)
                IDLE:    if (cfg_vld) state <= ISSUE;
                ISSUE:   if (tile_up & last_grp & last_flt & last_ifm) state <= FINISH;
                FINISH:  if (cnt_out_nxt == '0) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: source/sya_ofm_drain.sv
`timescale 1ns/1ns
`include "sya_defines.svh"

module sya_ofm_drain import sya_cfg_pkg::*, sya_data_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  sya_cfg_t                   cfg,
    input  logic                       cfg_load,
    input  logic                       capture,
    input  psum_row_t [`SYA_NUM_ROW-1:0] psum_all,
    output logic                       buf_free,
    output logic                       tile_done,
    output ofm_wr_t                    ofm_wr,
    output logic                       ofm_wr_vld,
    input  logic                       ofm_wr_rdy
);

    localparam int ROW       = `SYA_NUM_ROW;
    localparam int COL       = `SYA_NUM_COL;
    localparam int ADDR_W    = `SYA_ADDR_W;
    localparam int ROW_IDX_W = $clog2(ROW);

    ofm_word_t [ROW-1:0]  q_next;
    ofm_word_t [ROW-1:0]  q_tile;
    logic [ROW_IDX_W-1:0] row_idx;
    logic [ADDR_W-1:0]    tile_cnt;
    logic                 busy;
    logic                 wr_hs;

    // ReLU, then shift down and add the zero point
    function automatic logic [`SYA_QNT_W-1:0] quant(
        input psum_t                 v,
        input logic [`SYA_QNT_W-1:0] sh,
        input logic [`SYA_QNT_W-1:0] zp
    );
        psum_t sv;
        sv = v >> sh;
        if (v < 0) begin
            return '0;
        end
        return sv[`SYA_QNT_W-1:0] + zp;
    endfunction

    always_comb begin
        for (int r = 0; r < ROW; r++) begin
            for (int c = 0; c < COL; c++) begin
                q_next[r][c] = quant(psum_all[r][c], cfg.shift, cfg.zp);
            end
        end
    end

    // ==============================
    // Row write-out
    // ==============================
    assign buf_free    = ~busy;
    assign ofm_wr_vld  = busy;
    assign wr_hs       = busy & ofm_wr_rdy;
    assign ofm_wr.data = q_tile[row_idx];
    assign ofm_wr.addr = cfg.ofm_base + tile_cnt * ADDR_W'(ROW) + ADDR_W'(row_idx);

    always_ff @(posedge clk) begin
        if (capture) begin
            q_tile <= q_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            tile_done <= 1'b0;
            row_idx   <= '0;
            tile_cnt  <= '0;
        end else begin
            tile_done <= wr_hs & (row_idx == ROW_IDX_W'(ROW - 1));
            if (capture) begin
                busy <= 1'b1;
            end else if (wr_hs) begin
                if (row_idx == ROW_IDX_W'(ROW - 1)) begin
                    busy     <= 1'b0;
                    row_idx  <= '0;
                    tile_cnt <= tile_cnt + 1'b1;
                end else begin
                    row_idx <= row_idx + 1'b1;
                end
            end
            // New job restarts output tile numbering
            if (cfg_load) begin
                tile_cnt <= '0;
            end
        end
    end

endmodule

// File: source/sya_pe_row.sv
`timescale 1ns/1ns
`include "sya_defines.svh"

module sya_pe_row import sya_data_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      step,
    input  logic      capture,
    input  act_t      act_in,
    input  wgt_row_t  wgt_in,
    output wgt_row_t  wgt_out,
    output psum_row_t psum
);

    localparam int COL = `SYA_NUM_COL;

    // East-going activation registers, none past the last column
    act_t  act_q  [COL-1];
    act_t  act_pe [COL];
    psum_t prod   [COL];

    always_comb begin
        act_pe[0] = act_in;
        for (int c = 1; c < COL; c++) begin
            act_pe[c] = act_q[c-1];
        end
        for (int c = 0; c < COL; c++) begin
            prod[c] = act_pe[c] * wgt_in[c];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < COL - 1; c++) begin
                act_q[c] <= '0;
            end
            wgt_out <= '0;
            psum    <= '0;
        end else begin
            if (step) begin
                for (int c = 0; c < COL - 1; c++) begin
                    act_q[c] <= act_pe[c];
                end
                wgt_out <= wgt_in;
            end
            // Drain has taken the tile, start the next one from zero
            if (capture) begin
                psum <= '0;
            end else if (step) begin
                for (int c = 0; c < COL; c++) begin
                    psum[c] <= psum[c] + prod[c];
                end
            end
        end
    end

endmodule

// File: source/sya_skew_feeder.sv
`timescale 1ns/1ns
`include "sya_defines.svh"

module sya_skew_feeder import sya_cfg_pkg::*, sya_data_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  sya_cfg_t cfg,
    input  act_col_t act_dat,
    input  logic     act_dat_vld,
    input  wgt_row_t wgt_dat,
    input  logic     wgt_dat_vld,
    output logic     dat_rdy,
    input  logic     buf_free,
    output logic     step,
    output logic     capture,
    output act_col_t skew_act,
    output wgt_row_t skew_wgt
);

    localparam int ROW         = `SYA_NUM_ROW;
    localparam int COL         = `SYA_NUM_COL;
    localparam int FLUSH_CNT_W = $clog2(`SYA_FLUSH_STEPS + 1);

    typedef enum logic [1:0] {FEED, FLUSH, CAPT} feed_st_e;

    feed_st_e               state;
    logic [`SYA_CHN_W-1:0]  cnt_chn;
    logic [FLUSH_CNT_W-1:0] cnt_flush;
    logic                   beat;
    logic                   flushing;
    act_col_t               act_src;
    wgt_row_t               wgt_src;
    // Stage d holds the whole word delayed by d+1 steps
    act_col_t               act_sr [ROW-1];
    wgt_row_t               wgt_sr [COL-1];

    assign dat_rdy  = state == FEED;
    assign beat     = dat_rdy & act_dat_vld & wgt_dat_vld;
    assign flushing = state == FLUSH;
    assign step     = beat | flushing;
    assign capture  = (state == CAPT) & buf_free;

    // Zeros drain the array during flush
    assign act_src = flushing ? '0 : act_dat;
    assign wgt_src = flushing ? '0 : wgt_dat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FEED;
            cnt_chn   <= '0;
            cnt_flush <= '0;
        end else begin
            case (state)
                FEED: begin
                    if (beat) begin
                        if (cnt_chn == cfg.chn - 1'b1) begin
                            cnt_chn <= '0;
                            state   <= FLUSH;
                        end else begin
                            cnt_chn <= cnt_chn + 1'b1;
                        end
                    end
                end
                FLUSH: begin
                    if (cnt_flush == FLUSH_CNT_W'(`SYA_FLUSH_STEPS - 1)) begin
                        cnt_flush <= '0;
                        state     <= CAPT;
                    end else begin
                        cnt_flush <= cnt_flush + 1'b1;
                    end
                end
                CAPT:    if (buf_free) state <= FEED;
                default: state <= FEED;
            endcase
        end
    end

    // ==============================
    // Skew delay lines
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < ROW - 1; d++) begin
                act_sr[d] <= '0;
            end
            for (int d = 0; d < COL - 1; d++) begin
                wgt_sr[d] <= '0;
            end
        end else if (step) begin
            act_sr[0] <= act_src;
            wgt_sr[0] <= wgt_src;
            for (int d = 1; d < ROW - 1; d++) begin
                act_sr[d] <= act_sr[d-1];
            end
            for (int d = 1; d < COL - 1; d++) begin
                wgt_sr[d] <= wgt_sr[d-1];
            end
        end
    end

    // Row r taps delay r, column c taps delay c
    always_comb begin
        skew_act[0] = act_src[0];
        skew_wgt[0] = wgt_src[0];
        for (int r = 1; r < ROW; r++) begin
            skew_act[r] = act_sr[r-1][r];
        end
        for (int c = 1; c < COL; c++) begin
            skew_wgt[c] = wgt_sr[c-1][c];
        end
    end

endmodule

// File: source/sya_top.sv
`timescale 1ns/1ns
`include "sya_defines.svh"

module sya_top import sya_cfg_pkg::*, sya_data_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sya_cfg_t               cfg_in,
    input  logic                   cfg_vld,
    output logic                   cfg_rdy,
    output logic [`SYA_ADDR_W-1:0] act_addr,
    output logic                   act_addr_vld,
    input  logic                   act_addr_rdy,
    output logic [`SYA_ADDR_W-1:0] wgt_addr,
    output logic                   wgt_addr_vld,
    input  logic                   wgt_addr_rdy,
    input  act_col_t               act_dat,
    input  logic                   act_dat_vld,
    input  wgt_row_t               wgt_dat,
    input  logic                   wgt_dat_vld,
    output logic                   dat_rdy,
    output ofm_wr_t                ofm_wr,
    output logic                   ofm_wr_vld,
    input  logic                   ofm_wr_rdy
);

    localparam int ROW = `SYA_NUM_ROW;

    sya_cfg_t             cfg;
    logic                 cfg_load;
    logic                 step;
    logic                 capture;
    logic                 buf_free;
    logic                 tile_done;
    act_col_t             skew_act;
    wgt_row_t             skew_wgt;
    // Entry r feeds row r, the last one leaves the bottom row
    wgt_row_t             wgt_chain [ROW+1];
    psum_row_t [ROW-1:0]  psum_all;

    sya_loop_seq u_loop_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_in       (cfg_in),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .cfg          (cfg),
        .cfg_load     (cfg_load),
        .act_addr     (act_addr),
        .act_addr_vld (act_addr_vld),
        .act_addr_rdy (act_addr_rdy),
        .wgt_addr     (wgt_addr),
        .wgt_addr_vld (wgt_addr_vld),
        .wgt_addr_rdy (wgt_addr_rdy),
        .tile_done    (tile_done)
    );

    sya_skew_feeder u_skew_feeder (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .act_dat     (act_dat),
        .act_dat_vld (act_dat_vld),
        .wgt_dat     (wgt_dat),
        .wgt_dat_vld (wgt_dat_vld),
        .dat_rdy     (dat_rdy),
        .buf_free    (buf_free),
        .step        (step),
        .capture     (capture),
        .skew_act    (skew_act),
        .skew_wgt    (skew_wgt)
    );

    // ==============================
    // PE array
    // ==============================
    assign wgt_chain[0] = skew_wgt;

    for (genvar r = 0; r < ROW; r++) begin : g_row
        sya_pe_row u_pe_row (
            .clk     (clk),
            .rst_n   (rst_n),
            .step    (step),
            .capture (capture),
            .act_in  (skew_act[r]),
            .wgt_in  (wgt_chain[r]),
            .wgt_out (wgt_chain[r+1]),
            .psum    (psum_all[r])
        );
    end

    sya_ofm_drain u_ofm_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .cfg_load   (cfg_load),
        .capture    (capture),
        .psum_all   (psum_all),
        .buf_free   (buf_free),
        .tile_done  (tile_done),
        .ofm_wr     (ofm_wr),
        .ofm_wr_vld (ofm_wr_vld),
        .ofm_wr_rdy (ofm_wr_rdy)
    );

endmodule

// File: verilog.f
+incdir+source
source/sya_cfg_pkg.sv
source/sya_data_pkg.sv
source/sya_loop_seq.sv
source/sya_skew_feeder.sv
source/sya_pe_row.sv
source/sya_ofm_drain.sv
source/sya_top.sv
bench/tb_sya.sv
